/* logic/fifo_pkg.sv */
// shared sizes and APB register map for the FIFO subsystem, imported by the register block
`default_nettype none

package fifo_pkg;

   // default geometry, overridden through top level parameters
   parameter int DATA_WIDTH_DEF = 8;
   parameter int DEPTH_DEF      = 4;

   // register byte addresses on the APB port
   typedef enum logic [7:0] {
      REG_CTRL      = 8'h00,
      REG_STATUS    = 8'h04,
      REG_DROP_CNT  = 8'h08,
      REG_UNDER_CNT = 8'h0C
   } reg_addr_e;

   // bit positions inside REG_CTRL
   parameter int CTRL_ENABLE_BIT = 0;
   parameter int CTRL_CLEAR_BIT  = 1;

   // event counters saturate at all ones
   parameter int CNT_WIDTH = 16;

endpackage

`default_nettype wire

/* logic/fifo_ptr_if.sv */
// pointer and flag bundle between the FIFO pointer tracker and the FIFO core
`timescale 1ns/10ps
`default_nettype none

interface fifo_ptr_if #(
   parameter int DEPTH = fifo_pkg::DEPTH_DEF
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   // tracker to core
   logic [PTR_W-1:0] wptr;
   logic [PTR_W-1:0] rptr_next;
   logic             full;
   logic             empty;
   logic [CNT_W-1:0] count;

   // core to tracker, accepted handshakes only
   logic             enq;
   logic             deq;

   modport tracker (
      output wptr, rptr_next, full, empty, count,
      input  enq, deq
   );

   modport core (
      input  wptr, rptr_next, full, empty, count,
      output enq, deq
   );

endinterface

`default_nettype wire

/* logic/fifo_ptr_tracker.sv */
// read and write pointer bookkeeping for the small FIFO, instantiated inside the FIFO core
`timescale 1ns/10ps
`default_nettype none

module fifo_ptr_tracker #(
   parameter int DEPTH = fifo_pkg::DEPTH_DEF
) (
   input  logic       clk_i,
   input  logic       rst_n_i,
   fifo_ptr_if.tracker ptr
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

   logic [PTR_W-1:0] rptr_q;
   logic [PTR_W-1:0] wptr_q;
   logic             last_enq_q;
   logic [CNT_W-1:0] count_q;
   logic             ptrs_equal;

   // pointers wrap at DEPTH so non power of two depths work
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      logic [PTR_W-1:0] nxt;
      if (p == LAST_PTR)
         nxt = '0;
      else
         nxt = p + 1'b1;
      return nxt;
   endfunction

   // look-ahead read address, the RAM registers it this cycle
   assign ptr.rptr_next = ptr.deq ? ptr_inc(rptr_q) : rptr_q;
   assign ptr.wptr      = wptr_q;

   // equal pointers mean full or empty
   // the last operation tells which one
   assign ptrs_equal = (rptr_q == wptr_q);
   assign ptr.full   = ptrs_equal & last_enq_q;
   assign ptr.empty  = ptrs_equal & ~last_enq_q;
   assign ptr.count  = count_q;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         rptr_q     <= '0;
         wptr_q     <= '0;
         last_enq_q <= 1'b0;
         count_q    <= '0;
      end
      else
      begin
         rptr_q <= ptr.rptr_next;
         if (ptr.enq)
            wptr_q <= ptr_inc(wptr_q);
         // simultaneous enq and deq keep the distance, so the bit stays
         if (ptr.enq ^ ptr.deq)
            last_enq_q <= ptr.enq;
         case ({ptr.enq, ptr.deq})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // the core must gate its strobes with the flags computed here
   a_no_enq_when_full : assert property (
      @(posedge clk_i) disable iff (!rst_n_i) !(ptr.enq && ptr.full)
   ) else $error("fifo_ptr_tracker: enq while full");

   a_no_deq_when_empty : assert property (
      @(posedge clk_i) disable iff (!rst_n_i) !(ptr.deq && ptr.empty)
   ) else $error("fifo_ptr_tracker: deq while empty");

endmodule

`default_nettype wire

/* logic/sync_ram_1r1w.sv */
// one write port, one registered read port storage array used by the FIFO core
`timescale 1ns/10ps
`default_nettype none

module sync_ram_1r1w #(
   parameter int DATA_WIDTH = fifo_pkg::DATA_WIDTH_DEF,
   parameter int DEPTH      = fifo_pkg::DEPTH_DEF
) (
   input  logic                     clk_i,
   input  logic                     w_en_i,
   input  logic [$clog2(DEPTH)-1:0] w_addr_i,
   input  logic [DATA_WIDTH-1:0]    w_data_i,
   input  logic                     r_en_i,
   input  logic [$clog2(DEPTH)-1:0] r_addr_i,
   output logic [DATA_WIDTH-1:0]    r_data_o
);

   logic [DATA_WIDTH-1:0] mem [DEPTH];

   // synchronous write
   always_ff @(posedge clk_i)
   begin
      if (w_en_i)
         mem[w_addr_i] <= w_data_i;
   end

   // registered read, output holds while r_en_i is low
   always_ff @(posedge clk_i)
   begin
      if (r_en_i)
         r_data_o <= mem[r_addr_i];
   end

   // the core steers colliding reads to its bypass register
   a_no_same_addr : assert property (
      @(posedge clk_i) !(w_en_i && r_en_i && (w_addr_i == r_addr_i))
   ) else $error("sync_ram_1r1w: read and write to the same address");

endmodule

`default_nettype wire

/* logic/fifo_small_bypass.sv */
// small FIFO core with valid/ready input, valid/yumi output and write-to-read bypass
`timescale 1ns/10ps
`default_nettype none

module fifo_small_bypass #(
   parameter int DATA_WIDTH = fifo_pkg::DATA_WIDTH_DEF,
   parameter int DEPTH      = fifo_pkg::DEPTH_DEF
) (
   input  logic                       clk_i,
   input  logic                       rst_n_i,
   input  logic                       enable_i,
   input  logic                       valid_i,
   output logic                       ready_o,
   input  logic [DATA_WIDTH-1:0]      data_i,
   output logic                       valid_o,
   output logic [DATA_WIDTH-1:0]      data_o,
   input  logic                       yumi_i,
   output logic [$clog2(DEPTH+1)-1:0] count_o,
   output logic                       full_o,
   output logic                       empty_o,
   output logic                       push_refused_o,
   output logic                       pop_refused_o
);

   logic                  same_addr_n;
   logic                  same_addr_q;
   logic [DATA_WIDTH-1:0] ram_rdata;
   logic [DATA_WIDTH-1:0] bypass_q;

   fifo_ptr_if #(.DEPTH(DEPTH)) ptr ();

   fifo_ptr_tracker #(.DEPTH(DEPTH)) u_tracker (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .ptr     (ptr.tracker)
   );

   // input side accepts only when enabled and there is room
   assign ready_o = enable_i & ~ptr.full;
   assign ptr.enq = valid_i & ready_o;

   // pops on an empty FIFO are dropped here and reported
   assign valid_o = ~ptr.empty;
   assign ptr.deq = yumi_i & ~ptr.empty;

   // write lands where the RAM would read next
   // happens when empty, or one word with push and pop together
   assign same_addr_n = ptr.enq & (ptr.wptr == ptr.rptr_next);

   // read is skipped on a collision so the RAM never sees one
   sync_ram_1r1w #(
      .DATA_WIDTH (DATA_WIDTH),
      .DEPTH      (DEPTH)
   ) u_ram (
      .clk_i    (clk_i),
      .w_en_i   (ptr.enq),
      .w_addr_i (ptr.wptr),
      .w_data_i (data_i),
      .r_en_i   (~same_addr_n),
      .r_addr_i (ptr.rptr_next),
      .r_data_o (ram_rdata)
   );

   // bypass copy of the colliding write
   always_ff @(posedge clk_i)
   begin
      if (same_addr_n)
         bypass_q <= data_i;
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         same_addr_q <= 1'b0;
      else
         same_addr_q <= same_addr_n;
   end

   // one cycle after a collision the head word sits in the bypass register
   assign data_o = same_addr_q ? bypass_q : ram_rdata;

   // status and refused-event pulses, one per offending cycle
   assign count_o        = ptr.count;
   assign full_o         = ptr.full;
   assign empty_o        = ptr.empty;
   assign push_refused_o = valid_i & ~ready_o;
   assign pop_refused_o  = yumi_i & ptr.empty;

endmodule

`default_nettype wire

/* logic/fifo_apb_regs.sv */
// APB register block for FIFO control, status and refused-event counters
`timescale 1ns/10ps
`default_nettype none

module fifo_apb_regs #(
   parameter int DEPTH = fifo_pkg::DEPTH_DEF
) (
   input  logic                       clk_i,
   input  logic                       rst_n_i,
   input  logic                       psel_i,
   input  logic                       penable_i,
   input  logic                       pwrite_i,
   input  logic [7:0]                 paddr_i,
   input  logic [31:0]                pwdata_i,
   output logic [31:0]                prdata_o,
   output logic                       pready_o,
   output logic                       pslverr_o,
   output logic                       enable_o,
   input  logic [$clog2(DEPTH+1)-1:0] count_i,
   input  logic                       full_i,
   input  logic                       empty_i,
   input  logic                       push_refused_i,
   input  logic                       pop_refused_i
);

   import fifo_pkg::*;

   logic                 access;
   logic                 wr_en;
   logic                 rd_en;
   logic                 addr_hit;
   logic                 addr_ro;
   logic                 ctrl_wr;
   logic                 clear_cnt;
   logic                 enable_q;
   logic [1:0]           event_pulse;
   logic [CNT_WIDTH-1:0] cnt_q [2];
   logic [31:0]          status_word;

   // no wait states
   assign pready_o = 1'b1;

   // access phase of a transfer
   assign access = psel_i & penable_i;
   assign wr_en  = access & pwrite_i;
   assign rd_en  = access & ~pwrite_i;

   // address decode
   // only REG_CTRL is writable
   always_comb
   begin
      addr_hit = 1'b0;
      addr_ro  = 1'b0;
      case (paddr_i)
         REG_CTRL:
            addr_hit = 1'b1;
         REG_STATUS, REG_DROP_CNT, REG_UNDER_CNT:
         begin
            addr_hit = 1'b1;
            addr_ro  = 1'b1;
         end
         default:
            addr_hit = 1'b0;
      endcase
   end

   // error on unmapped address or write to a read-only register
   assign pslverr_o = access & (~addr_hit | (pwrite_i & addr_ro));

   assign ctrl_wr   = wr_en & (paddr_i == REG_CTRL);
   assign clear_cnt = ctrl_wr & pwdata_i[CTRL_CLEAR_BIT];

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         enable_q <= 1'b0;
      else if (ctrl_wr)
         enable_q <= pwdata_i[CTRL_ENABLE_BIT];
   end

   assign enable_o = enable_q;

   // index 0 counts refused pushes, index 1 illegal pops
   assign event_pulse = {pop_refused_i, push_refused_i};

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         cnt_q <= '{default: '0};
      else if (clear_cnt)
         cnt_q <= '{default: '0};
      else
      begin
         for (int i = 0; i < 2; i++)
         begin
            // stick at all ones
            if (event_pulse[i] && (cnt_q[i] != '1))
               cnt_q[i] <= cnt_q[i] + 1'b1;
         end
      end
   end

   // count in 15:0, full in 16, empty in 17
   assign status_word = {14'b0, empty_i, full_i, 16'(count_i)};

   // read data valid in the access cycle
   // clear bit always reads back as 0
   always_comb
   begin
      prdata_o = '0;
      if (rd_en)
      begin
         case (paddr_i)
            REG_CTRL:      prdata_o[CTRL_ENABLE_BIT] = enable_q;
            REG_STATUS:    prdata_o = status_word;
            REG_DROP_CNT:  prdata_o[CNT_WIDTH-1:0] = cnt_q[0];
            REG_UNDER_CNT: prdata_o[CNT_WIDTH-1:0] = cnt_q[1];
            default:       prdata_o = '0;
         endcase
      end
   end

   // access phase only ever follows a selected setup phase
   a_penable_needs_psel : assert property (
      @(posedge clk_i) disable iff (!rst_n_i) penable_i |-> psel_i
   ) else $error("fifo_apb_regs: penable without psel");

endmodule

`default_nettype wire

/* logic/fifo_subsystem_top.sv */
// top level of the FIFO subsystem, joins the APB register block and the FIFO core
`timescale 1ns/10ps
`default_nettype none

module fifo_subsystem_top #(
   parameter int DATA_WIDTH = fifo_pkg::DATA_WIDTH_DEF,
   parameter int DEPTH      = fifo_pkg::DEPTH_DEF
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   // APB slave
   input  logic                  psel_i,
   input  logic                  penable_i,
   input  logic                  pwrite_i,
   input  logic [7:0]            paddr_i,
   input  logic [31:0]           pwdata_i,
   output logic [31:0]           prdata_o,
   output logic                  pready_o,
   output logic                  pslverr_o,
   // data path
   input  logic                  valid_i,
   output logic                  ready_o,
   input  logic [DATA_WIDTH-1:0] data_i,
   output logic                  valid_o,
   output logic [DATA_WIDTH-1:0] data_o,
   input  logic                  yumi_i
);

   logic                       enable;
   logic [$clog2(DEPTH+1)-1:0] count;
   logic                       full;
   logic                       empty;
   logic                       push_refused;
   logic                       pop_refused;

   fifo_apb_regs #(.DEPTH(DEPTH)) u_regs (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .psel_i         (psel_i),
      .penable_i      (penable_i),
      .pwrite_i       (pwrite_i),
      .paddr_i        (paddr_i),
      .pwdata_i       (pwdata_i),
      .prdata_o       (prdata_o),
      .pready_o       (pready_o),
      .pslverr_o      (pslverr_o),
      .enable_o       (enable),
      .count_i        (count),
      .full_i         (full),
      .empty_i        (empty),
      .push_refused_i (push_refused),
      .pop_refused_i  (pop_refused)
   );

   fifo_small_bypass #(
      .DATA_WIDTH (DATA_WIDTH),
      .DEPTH      (DEPTH)
   ) u_fifo (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .enable_i       (enable),
      .valid_i        (valid_i),
      .ready_o        (ready_o),
      .data_i         (data_i),
      .valid_o        (valid_o),
      .data_o         (data_o),
      .yumi_i         (yumi_i),
      .count_o        (count),
      .full_o         (full),
      .empty_o        (empty),
      .push_refused_o (push_refused),
      .pop_refused_o  (pop_refused)
   );

endmodule

`default_nettype wire

/* tests/tb_fifo_subsystem.sv */
// self-checking testbench for the FIFO subsystem, run as top module with the file list
`timescale 1ns/10ps
`default_nettype none

module tb_fifo_subsystem;

   import fifo_pkg::*;

   localparam int DATA_WIDTH     = 8;
   localparam int DEPTH          = 4;
   localparam int PERIOD         = 100;
   localparam int N_RANDOM       = 300;
   // two random phases plus register accesses and directed phases
   localparam int PLANNED_CYCLES = 2 * N_RANDOM + 150;

   logic                  clk_i;
   logic                  rst_n_i;
   logic                  psel_i;
   logic                  penable_i;
   logic                  pwrite_i;
   logic [7:0]            paddr_i;
   logic [31:0]           pwdata_i;
   logic [31:0]           prdata_o;
   logic                  pready_o;
   logic                  pslverr_o;
   logic                  valid_i;
   logic                  ready_o;
   logic [DATA_WIDTH-1:0] data_i;
   logic                  valid_o;
   logic [DATA_WIDTH-1:0] data_o;
   logic                  yumi_i;

   // reference model state
   logic [DATA_WIDTH-1:0] ref_q [$];
   logic                  en_model;
   logic [15:0]           drop_cnt;
   logic [15:0]           under_cnt;
   logic [31:0]           lcg_state;
   int                    errors;

   fifo_subsystem_top #(
      .DATA_WIDTH (DATA_WIDTH),
      .DEPTH      (DEPTH)
   ) DUT (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o),
      .pslverr_o (pslverr_o),
      .valid_i   (valid_i),
      .ready_o   (ready_o),
      .data_i    (data_i),
      .valid_o   (valid_o),
      .data_o    (data_o),
      .yumi_i    (yumi_i)
   );

   always #(PERIOD / 2) clk_i = ~clk_i;

   task automatic fail_msg(input string msg);
      errors++;
      $display("Fail at %0t ns: %s", $time, msg);
   endtask

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // push into an empty FIFO shows up one cycle later with its data
   push_to_output : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (valid_i && ready_o && !valid_o) |=> (valid_o && data_o == $past(data_i))
   ) else fail_msg("push into empty FIFO not visible on the next cycle");

   // no wait states, and errors only in the access phase
   ready_always : assert property (
      @(posedge clk_i) disable iff (!rst_n_i) pready_o
   ) else fail_msg("pready_o low");

   slverr_in_access : assert property (
      @(posedge clk_i) disable iff (!rst_n_i) pslverr_o |-> (psel_i && penable_i)
   ) else fail_msg("pslverr_o outside an access phase");

   // outputs reflect the state after the last rising edge
   task automatic check_outputs();
      assert (valid_o == (ref_q.size() != 0))
         else fail_msg("valid_o does not match reference occupancy");
      if (valid_o && ref_q.size() != 0)
         assert (data_o == ref_q[0])
            else fail_msg($sformatf("data_o %h, expected %h", data_o, ref_q[0]));
      assert (ready_o == (en_model && ref_q.size() < DEPTH))
         else fail_msg("ready_o does not match enable and occupancy");
   endtask

   // one cycle of data traffic, driven on the falling edge
   task automatic tick(input logic v, input logic [DATA_WIDTH-1:0] d, input logic y);
      logic exp_ready;
      logic exp_valid;
      @(negedge clk_i);
      check_outputs();
      // handshake outcome follows the reference state before the coming edge
      exp_ready = en_model && (ref_q.size() < DEPTH);
      exp_valid = (ref_q.size() != 0);
      valid_i = v;
      data_i  = d;
      yumi_i  = y;
      if (y && exp_valid)
         void'(ref_q.pop_front());
      if (v && exp_ready)
         ref_q.push_back(d);
      if (v && !exp_ready && drop_cnt != 16'hFFFF)
         drop_cnt++;
      if (y && !exp_valid && under_cnt != 16'hFFFF)
         under_cnt++;
   endtask

   function automatic logic [31:0] reg_expected(input logic [7:0] addr);
      logic [31:0] val;
      val = '0;
      case (addr)
         REG_CTRL:
            val[CTRL_ENABLE_BIT] = en_model;
         REG_STATUS:
         begin
            val[15:0] = 16'(ref_q.size());
            val[16]   = (ref_q.size() == DEPTH);
            val[17]   = (ref_q.size() == 0);
         end
         REG_DROP_CNT:  val[15:0] = drop_cnt;
         REG_UNDER_CNT: val[15:0] = under_cnt;
         default:       val = '0;
      endcase
      return val;
   endfunction

   // setup, access, then back to idle; data path stays quiet
   task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata);
      logic        mapped;
      logic [31:0] exp_data;
      mapped = (addr == REG_CTRL) || (addr == REG_STATUS) ||
               (addr == REG_DROP_CNT) || (addr == REG_UNDER_CNT);
      tick(1'b0, '0, 1'b0);
      psel_i   = 1'b1;
      pwrite_i = wr;
      paddr_i  = addr;
      pwdata_i = wdata;
      tick(1'b0, '0, 1'b0);
      penable_i = 1'b1;
      exp_data  = reg_expected(addr);
      #(PERIOD / 4);
      if (wr)
      begin
         assert (pslverr_o == (addr != REG_CTRL))
            else fail_msg($sformatf("pslverr_o %b on write to %h", pslverr_o, addr));
         if (addr == REG_CTRL)
         begin
            en_model = wdata[CTRL_ENABLE_BIT];
            if (wdata[CTRL_CLEAR_BIT])
            begin
               drop_cnt  = '0;
               under_cnt = '0;
            end
         end
      end
      else
      begin
         assert (pslverr_o == !mapped)
            else fail_msg($sformatf("pslverr_o %b on read of %h", pslverr_o, addr));
         assert (prdata_o == exp_data)
            else fail_msg($sformatf("read %h gave %h, expected %h", addr, prdata_o, exp_data));
      end
      tick(1'b0, '0, 1'b0);
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
   endtask

   task automatic read_all_regs();
      apb_access(1'b0, REG_CTRL, '0);
      apb_access(1'b0, REG_STATUS, '0);
      apb_access(1'b0, REG_DROP_CNT, '0);
      apb_access(1'b0, REG_UNDER_CNT, '0);
   endtask

   task automatic random_phase(input int cycles, input logic bias_full);
      logic [31:0] r;
      for (int i = 0; i < cycles; i++)
      begin
         r = lcg_next();
         // even mix keeps the FIFO near empty, the biased one near full
         if (bias_full)
            tick(r[8] | r[9], r[23:16], r[10] & r[11]);
         else
            tick(r[8], r[23:16], r[9]);
      end
   endtask

   task automatic drain();
      for (int i = 0; i < 2 * DEPTH && ref_q.size() != 0; i++)
         tick(1'b0, '0, 1'b1);
   endtask

   // watchdog sized from the planned cycle count plus a margin
   initial
   begin
      #((PLANNED_CYCLES + 200) * PERIOD);
      $display("Timeout: test did not finish within %0d cycles", PLANNED_CYCLES + 200);
      $display("Errors found");
      $finish;
   end

   initial
   begin
      clk_i     = 1'b0;
      rst_n_i   = 1'b0;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = '0;
      pwdata_i  = '0;
      valid_i   = 1'b0;
      data_i    = '0;
      yumi_i    = 1'b0;
      en_model  = 1'b0;
      drop_cnt  = '0;
      under_cnt = '0;
      lcg_state = 32'he957_99e9;
      errors    = 0;
      repeat (4) @(negedge clk_i);
      rst_n_i = 1'b1;

      // reset state, then pushes while disabled are refused
      assert (!ready_o && !valid_o && !pslverr_o) else fail_msg("outputs high after reset");
      read_all_regs();
      for (int i = 0; i < 3; i++)
         tick(1'b1, 8'(8'h30 + i), 1'b0);
      apb_access(1'b0, REG_DROP_CNT, '0);

      // enable, single push into empty, then pop it
      apb_access(1'b1, REG_CTRL, 32'h1);
      tick(1'b1, 8'hA5, 1'b0);
      tick(1'b0, '0, 1'b0);
      tick(1'b0, '0, 1'b1);

      random_phase(N_RANDOM, 1'b0);
      random_phase(N_RANDOM, 1'b1);
      drain();
      read_all_regs();

      // fill with yumi low, then keep offering while full
      apb_access(1'b1, REG_CTRL, 32'h3);
      for (int i = 0; i < DEPTH + 5; i++)
         tick(1'b1, 8'(8'hC0 + i), 1'b0);
      tick(1'b0, '0, 1'b0);
      apb_access(1'b0, REG_STATUS, '0);
      apb_access(1'b0, REG_DROP_CNT, '0);

      // illegal pops while empty, then clear both counters
      drain();
      for (int i = 0; i < 3; i++)
         tick(1'b0, '0, 1'b1);
      tick(1'b0, '0, 1'b0);
      apb_access(1'b0, REG_UNDER_CNT, '0);
      apb_access(1'b1, REG_CTRL, 32'h3);
      read_all_regs();

      // error responses leave registers alone
      // one illegal pop first so a stray counter clear would show
      tick(1'b0, '0, 1'b1);
      tick(1'b1, 8'h5A, 1'b0);
      tick(1'b0, '0, 1'b0);
      apb_access(1'b1, REG_STATUS, 32'hFFFF_FFFF);
      apb_access(1'b1, REG_DROP_CNT, 32'h3);
      apb_access(1'b1, 8'h10, 32'h0);
      apb_access(1'b0, 8'h14, '0);
      read_all_regs();
      drain();
      tick(1'b0, '0, 1'b0);

      $display("Summary: %0d errors", errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
logic/fifo_pkg.sv
logic/fifo_ptr_if.sv
logic/fifo_ptr_tracker.sv
logic/sync_ram_1r1w.sv
logic/fifo_small_bypass.sv
logic/fifo_apb_regs.sv
logic/fifo_subsystem_top.sv
tests/tb_fifo_subsystem.sv

/* Bender.yml */
package:
  name: fifo_subsystem

sources:
  - logic/fifo_pkg.sv
  - logic/fifo_ptr_if.sv
  - logic/fifo_ptr_tracker.sv
  - logic/sync_ram_1r1w.sv
  - logic/fifo_small_bypass.sv
  - logic/fifo_apb_regs.sv
  - logic/fifo_subsystem_top.sv
  - target: test
    files:
      - tests/tb_fifo_subsystem.sv
